// File: hw/dpc_pixel_pkg.sv
`default_nettype none

package dpc_pixel_pkg;

	localparam int pixel_width = 8;

	typedef logic [pixel_width-1:0] pixel_t;

	// all ones marks a direction with no valid candidate
	typedef logic [pixel_width-1:0] diff_t;

	// window word as it crosses the port, flag on top
	typedef union packed {
		logic [pixel_width:0] raw;
		struct packed {
			logic   bad;
			pixel_t value;
		} fields;
	} pixel_word_u;

	function automatic diff_t abs_diff(input pixel_t a, input pixel_t b);
		return (a > b) ? diff_t'(a - b) : diff_t'(b - a);
	endfunction

	// ties go to the second candidate
	function automatic logic first_wins(input logic v_a, input diff_t d_a,
		input logic v_b, input diff_t d_b);
		return v_a && (!v_b || (d_a < d_b));
	endfunction

endpackage

`default_nettype wire

// File: hw/dpc_stream_pkg.sv
`default_nettype none

package dpc_stream_pkg;

	// row and column counters
	localparam int coord_width = 10;

	// input edge to output edge, in clocks
	localparam int pipe_latency = 5;

	typedef logic [coord_width-1:0] coord_t;

endpackage

`default_nettype wire

// File: hw/dpc_window_prep.sv
`default_nettype none

module dpc_window_prep
	import dpc_pixel_pkg::*;
(
	input  pixel_word_u w11,
	input  pixel_word_u w12,
	input  pixel_word_u w13,
	input  pixel_word_u w21,
	input  pixel_word_u w22,
	input  pixel_word_u w23,
	input  pixel_word_u w31,
	input  pixel_word_u w32,
	input  pixel_word_u w33,
	input  logic        is_first_row,
	input  logic        is_last_row,
	input  logic        is_first_column,
	input  logic        is_last_column,
	output pixel_t      pix_11,
	output pixel_t      pix_12,
	output pixel_t      pix_13,
	output pixel_t      pix_21,
	output pixel_t      pix_22,
	output pixel_t      pix_23,
	output pixel_t      pix_31,
	output pixel_t      pix_32,
	output pixel_t      pix_33,
	output logic        bad_11,
	output logic        bad_12,
	output logic        bad_13,
	output logic        bad_21,
	output logic        bad_22,
	output logic        bad_23,
	output logic        bad_31,
	output logic        bad_32,
	output logic        bad_33
);

	pixel_t v11, v12, v13;
	pixel_t v21, v22, v23;
	pixel_t v31, v32, v33;

	assign v11 = w11.fields.value;
	assign v12 = w12.fields.value;
	assign v13 = w13.fields.value;
	assign v21 = w21.fields.value;
	assign v22 = w22.fields.value;
	assign v23 = w23.fields.value;
	assign v31 = w31.fields.value;
	assign v32 = w32.fields.value;
	assign v33 = w33.fields.value;

	// flags stay at their raw positions
	assign bad_11 = w11.fields.bad;
	assign bad_12 = w12.fields.bad;
	assign bad_13 = w13.fields.bad;
	assign bad_21 = w21.fields.bad;
	assign bad_22 = w22.fields.bad;
	assign bad_23 = w23.fields.bad;
	assign bad_31 = w31.fields.bad;
	assign bad_32 = w32.fields.bad;
	assign bad_33 = w33.fields.bad;

	////////////////////////////////////////////////////////////////////////////
	// border replication, row rule then column rule

	assign pix_11 = is_first_row ? (is_first_column ? v22 : v21) : (is_first_column ? v12 : v11);
	assign pix_12 = is_first_row ? v22 : v12;
	assign pix_13 = is_first_row ? (is_last_column ? v22 : v23) : (is_last_column ? v12 : v13);
	assign pix_21 = is_first_column ? v22 : v21;
	assign pix_22 = v22;
	assign pix_23 = is_last_column ? v22 : v23;
	assign pix_31 = is_last_row ? (is_first_column ? v22 : v21) : (is_first_column ? v32 : v31);
	assign pix_32 = is_last_row ? v22 : v32;
	assign pix_33 = is_last_row ? (is_last_column ? v22 : v23) : (is_last_column ? v32 : v33);

endmodule

`default_nettype wire

// File: hw/dpc_basic_select.sv
`default_nettype none

module dpc_basic_select
	import dpc_pixel_pkg::*;
(
	input  logic       aclk,
	input  logic       aresetn,
	input  pixel_t     pix_11,
	input  pixel_t     pix_12,
	input  pixel_t     pix_13,
	input  pixel_t     pix_21,
	input  pixel_t     pix_23,
	input  pixel_t     pix_31,
	input  pixel_t     pix_32,
	input  pixel_t     pix_33,
	input  logic       bad_11,
	input  logic       bad_12,
	input  logic       bad_13,
	input  logic       bad_21,
	input  logic       bad_23,
	input  logic       bad_31,
	input  logic       bad_32,
	input  logic       bad_33,
	output diff_t      basic_diff,
	output pixel_t     basic_mean,
	output logic [2:0] basic_count
);

	logic   valid_h, valid_v, valid_d1, valid_d2;
	diff_t  diff_h, diff_v, diff_d1, diff_d2;
	logic [pixel_width:0] sum_h, sum_v, sum_d1, sum_d2;

	// stage 1, horizontal against vertical and diagonal against diagonal
	logic       hv_valid, dd_valid;
	diff_t      hv_diff, dd_diff;
	pixel_t     hv_mean, dd_mean;
	logic [2:0] count_s1;

	assign valid_h  = !bad_21 && !bad_23;
	assign valid_v  = !bad_12 && !bad_32;
	assign valid_d1 = !bad_11 && !bad_33;
	assign valid_d2 = !bad_13 && !bad_31;

	assign diff_h  = abs_diff(pix_21, pix_23);
	assign diff_v  = abs_diff(pix_12, pix_32);
	assign diff_d1 = abs_diff(pix_11, pix_33);
	assign diff_d2 = abs_diff(pix_13, pix_31);

	// one extra bit so the floor mean cannot wrap
	assign sum_h  = {1'b0, pix_21} + {1'b0, pix_23};
	assign sum_v  = {1'b0, pix_12} + {1'b0, pix_32};
	assign sum_d1 = {1'b0, pix_11} + {1'b0, pix_33};
	assign sum_d2 = {1'b0, pix_13} + {1'b0, pix_31};

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			hv_valid    <= 1'b0;
			hv_diff     <= '0;
			hv_mean     <= '0;
			dd_valid    <= 1'b0;
			dd_diff     <= '0;
			dd_mean     <= '0;
			count_s1    <= '0;
			basic_diff  <= '0;
			basic_mean  <= '0;
			basic_count <= '0;
		end else begin
			hv_valid <= valid_h || valid_v;
			if (first_wins(valid_h, diff_h, valid_v, diff_v)) begin
				hv_diff <= diff_h;
				hv_mean <= sum_h[pixel_width:1];
			end else begin
				hv_diff <= valid_v ? diff_v : '1;
				hv_mean <= valid_v ? sum_v[pixel_width:1] : '0;
			end
			dd_valid <= valid_d1 || valid_d2;
			if (first_wins(valid_d1, diff_d1, valid_d2, diff_d2)) begin
				dd_diff <= diff_d1;
				dd_mean <= sum_d1[pixel_width:1];
			end else begin
				dd_diff <= valid_d2 ? diff_d2 : '1;
				dd_mean <= valid_d2 ? sum_d2[pixel_width:1] : '0;
			end
			count_s1 <= {2'b00, valid_h} + {2'b00, valid_v} + {2'b00, valid_d1} + {2'b00, valid_d2};

			// stage 2
			if (first_wins(hv_valid, hv_diff, dd_valid, dd_diff)) begin
				basic_diff <= hv_diff;
				basic_mean <= hv_mean;
			end else begin
				basic_diff <= dd_valid ? dd_diff : '1;
				basic_mean <= dd_valid ? dd_mean : '0;
			end
			basic_count <= count_s1;
		end
	end

endmodule

`default_nettype wire

// File: hw/dpc_adjacent_select.sv
`default_nettype none

module dpc_adjacent_select
	import dpc_pixel_pkg::*;
(
	input  logic   aclk,
	input  logic   aresetn,
	input  pixel_t pix_11,
	input  pixel_t pix_12,
	input  pixel_t pix_13,
	input  pixel_t pix_21,
	input  pixel_t pix_23,
	input  pixel_t pix_31,
	input  pixel_t pix_32,
	input  pixel_t pix_33,
	input  logic   bad_11,
	input  logic   bad_12,
	input  logic   bad_13,
	input  logic   bad_21,
	input  logic   bad_23,
	input  logic   bad_31,
	input  logic   bad_32,
	input  logic   bad_33,
	output diff_t  adj_diff,
	output pixel_t adj_value
);

	// candidates in group order up, down, left, right
	// even index is the first direction of its group
	logic   c_valid [8];
	diff_t  c_diff  [8];
	pixel_t c_value [8];

	logic   s1_valid [4];
	diff_t  s1_diff  [4];
	pixel_t s1_value [4];

	logic   s2_valid [2];
	diff_t  s2_diff  [2];
	pixel_t s2_value [2];

	assign c_valid[0] = !bad_11 && !bad_12 && !bad_21;
	assign c_diff[0]  = abs_diff(pix_11, pix_12);
	assign c_value[0] = pix_21;
	assign c_valid[1] = !bad_13 && !bad_12 && !bad_23;
	assign c_diff[1]  = abs_diff(pix_13, pix_12);
	assign c_value[1] = pix_23;

	assign c_valid[2] = !bad_31 && !bad_32 && !bad_21;
	assign c_diff[2]  = abs_diff(pix_31, pix_32);
	assign c_value[2] = pix_21;
	assign c_valid[3] = !bad_33 && !bad_32 && !bad_23;
	assign c_diff[3]  = abs_diff(pix_33, pix_32);
	assign c_value[3] = pix_23;

	assign c_valid[4] = !bad_11 && !bad_21 && !bad_12;
	assign c_diff[4]  = abs_diff(pix_11, pix_21);
	assign c_value[4] = pix_12;
	assign c_valid[5] = !bad_31 && !bad_21 && !bad_32;
	assign c_diff[5]  = abs_diff(pix_31, pix_21);
	assign c_value[5] = pix_32;

	assign c_valid[6] = !bad_13 && !bad_23 && !bad_12;
	assign c_diff[6]  = abs_diff(pix_13, pix_23);
	assign c_value[6] = pix_12;
	assign c_valid[7] = !bad_33 && !bad_23 && !bad_32;
	assign c_diff[7]  = abs_diff(pix_33, pix_23);
	assign c_value[7] = pix_32;

	////////////////////////////////////////////////////////////////////////////
	// three merge stages, 8 to 4 to 2 to 1

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			for (int i = 0; i < 4; i++) begin
				s1_valid[i] <= 1'b0;
				s1_diff[i]  <= '0;
				s1_value[i] <= '0;
			end
			for (int i = 0; i < 2; i++) begin
				s2_valid[i] <= 1'b0;
				s2_diff[i]  <= '0;
				s2_value[i] <= '0;
			end
			adj_diff  <= '0;
			adj_value <= '0;
		end else begin
			for (int i = 0; i < 4; i++) begin
				s1_valid[i] <= c_valid[2*i] || c_valid[2*i+1];
				if (first_wins(c_valid[2*i], c_diff[2*i], c_valid[2*i+1], c_diff[2*i+1])) begin
					s1_diff[i]  <= c_diff[2*i];
					s1_value[i] <= c_value[2*i];
				end else begin
					s1_diff[i]  <= c_valid[2*i+1] ? c_diff[2*i+1] : '1;
					s1_value[i] <= c_valid[2*i+1] ? c_value[2*i+1] : '0;
				end
			end
			// up with down, left with right
			for (int i = 0; i < 2; i++) begin
				s2_valid[i] <= s1_valid[2*i] || s1_valid[2*i+1];
				if (first_wins(s1_valid[2*i], s1_diff[2*i], s1_valid[2*i+1], s1_diff[2*i+1])) begin
					s2_diff[i]  <= s1_diff[2*i];
					s2_value[i] <= s1_value[2*i];
				end else begin
					s2_diff[i]  <= s1_valid[2*i+1] ? s1_diff[2*i+1] : '1;
					s2_value[i] <= s1_valid[2*i+1] ? s1_value[2*i+1] : '0;
				end
			end
			if (first_wins(s2_valid[0], s2_diff[0], s2_valid[1], s2_diff[1])) begin
				adj_diff  <= s2_diff[0];
				adj_value <= s2_value[0];
			end else begin
				adj_diff  <= s2_valid[1] ? s2_diff[1] : '1;
				adj_value <= s2_valid[1] ? s2_value[1] : '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/dpc_replace.sv
`default_nettype none

module dpc_replace
	import dpc_pixel_pkg::*;
	import dpc_stream_pkg::*;
(
	input  logic        aclk,
	input  logic        aresetn,
	input  logic        in_valid,
	input  coord_t      in_hcnt,
	input  coord_t      in_vcnt,
	input  pixel_t      center,
	input  logic        center_bad,
	input  diff_t       basic_diff,
	input  pixel_t      basic_mean,
	input  logic [2:0]  basic_count,
	input  diff_t       adj_diff,
	input  pixel_t      adj_value,
	output pixel_word_u out_pixel,
	output coord_t      out_hcnt,
	output coord_t      out_vcnt,
	output logic        out_valid
);

	// basic result held to meet the adjacent result
	diff_t      basic_diff_q;
	pixel_t     basic_mean_q;
	logic [2:0] basic_count_q;
	pixel_t     repl_q;

	// center is consumed by the stage 5 register itself
	pixel_t center_dly [pipe_latency-1];
	logic   bad_dly    [pipe_latency-1];
	coord_t hcnt_dly   [pipe_latency];
	coord_t vcnt_dly   [pipe_latency];
	logic   valid_dly  [pipe_latency];

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			basic_diff_q  <= '0;
			basic_mean_q  <= '0;
			basic_count_q <= '0;
			repl_q        <= '0;
			out_pixel.raw <= '0;
		end else begin
			basic_diff_q  <= basic_diff;
			basic_mean_q  <= basic_mean;
			basic_count_q <= basic_count;
			// stage 4, two valid basic directions always win
			if (basic_count_q >= 3'd2 || basic_diff_q < adj_diff) begin
				repl_q <= basic_mean_q;
			end else begin
				repl_q <= adj_value;
			end
			// stage 5
			out_pixel.fields.bad   <= bad_dly[pipe_latency-2];
			out_pixel.fields.value <= bad_dly[pipe_latency-2] ? repl_q : center_dly[pipe_latency-2];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// delay line for center, coordinates and valid

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			for (int i = 0; i < pipe_latency - 1; i++) begin
				center_dly[i] <= '0;
				bad_dly[i]    <= 1'b0;
			end
			for (int i = 0; i < pipe_latency; i++) begin
				hcnt_dly[i]  <= '0;
				vcnt_dly[i]  <= '0;
				valid_dly[i] <= 1'b0;
			end
		end else begin
			center_dly[0] <= center;
			bad_dly[0]    <= center_bad;
			for (int i = 1; i < pipe_latency - 1; i++) begin
				center_dly[i] <= center_dly[i-1];
				bad_dly[i]    <= bad_dly[i-1];
			end
			hcnt_dly[0]  <= in_hcnt;
			vcnt_dly[0]  <= in_vcnt;
			valid_dly[0] <= in_valid;
			for (int i = 1; i < pipe_latency; i++) begin
				hcnt_dly[i]  <= hcnt_dly[i-1];
				vcnt_dly[i]  <= vcnt_dly[i-1];
				valid_dly[i] <= valid_dly[i-1];
			end
		end
	end

	assign out_hcnt  = hcnt_dly[pipe_latency-1];
	assign out_vcnt  = vcnt_dly[pipe_latency-1];
	assign out_valid = valid_dly[pipe_latency-1];

endmodule

`default_nettype wire

// File: hw/dpc_top.sv
`default_nettype none

module dpc_top
	import dpc_pixel_pkg::*;
	import dpc_stream_pkg::*;
(
	input  logic        aclk,
	input  logic        aresetn,
	input  logic        in_valid,
	input  logic        is_first_row,
	input  logic        is_last_row,
	input  logic        is_first_column,
	input  logic        is_last_column,
	input  coord_t      in_hcnt,
	input  coord_t      in_vcnt,
	input  pixel_word_u w11,
	input  pixel_word_u w12,
	input  pixel_word_u w13,
	input  pixel_word_u w21,
	input  pixel_word_u w22,
	input  pixel_word_u w23,
	input  pixel_word_u w31,
	input  pixel_word_u w32,
	input  pixel_word_u w33,
	output pixel_word_u out_pixel,
	output coord_t      out_hcnt,
	output coord_t      out_vcnt,
	output logic        out_valid
);

	// replicated window, shared by both selectors
	pixel_t pix_11, pix_12, pix_13;
	pixel_t pix_21, pix_22, pix_23;
	pixel_t pix_31, pix_32, pix_33;
	logic   bad_11, bad_12, bad_13;
	logic   bad_21, bad_22, bad_23;
	logic   bad_31, bad_32, bad_33;

	diff_t      basic_diff;
	pixel_t     basic_mean;
	logic [2:0] basic_count;
	diff_t      adj_diff;
	pixel_t     adj_value;

	dpc_window_prep window_prep_i (.*);

	// stages 1 and 2
	dpc_basic_select basic_select_i (.*);

	// stages 1 to 3
	dpc_adjacent_select adjacent_select_i (.*);

	// stages 4 and 5
	dpc_replace replace_i (
		.aclk        (aclk),
		.aresetn     (aresetn),
		.in_valid    (in_valid),
		.in_hcnt     (in_hcnt),
		.in_vcnt     (in_vcnt),
		.center      (pix_22),
		.center_bad  (bad_22),
		.basic_diff  (basic_diff),
		.basic_mean  (basic_mean),
		.basic_count (basic_count),
		.adj_diff    (adj_diff),
		.adj_value   (adj_value),
		.out_pixel   (out_pixel),
		.out_hcnt    (out_hcnt),
		.out_vcnt    (out_vcnt),
		.out_valid   (out_valid)
	);

endmodule

`default_nettype wire

// File: sim/dpc_top_assert.sv
`default_nettype none

module dpc_top_assert
	import dpc_pixel_pkg::*;
	import dpc_stream_pkg::*;
(
	input logic        aclk,
	input logic        aresetn,
	input logic        in_valid,
	input logic        out_valid,
	input pixel_word_u w22,
	input pixel_word_u out_pixel
);

	// valid trails the input by the pipeline depth
	assert property (@(posedge aclk) disable iff (!aresetn)
		out_valid == $past(in_valid, pipe_latency))
	else $error("out_valid does not follow in_valid by %0d cycles", pipe_latency);

	// held reset keeps the output quiet
	assert property (@(posedge aclk) (!aresetn && !$past(aresetn)) |-> !out_valid)
	else $error("out_valid high while reset is held");

	// output flag is the center flag of the same pixel
	assert property (@(posedge aclk) disable iff (!aresetn)
		out_valid |-> out_pixel.fields.bad == $past(w22.fields.bad, pipe_latency))
	else $error("out_pixel bad flag does not match the delayed center flag");

endmodule

bind dpc_top dpc_top_assert dpc_top_assert_i (
	.aclk      (aclk),
	.aresetn   (aresetn),
	.in_valid  (in_valid),
	.out_valid (out_valid),
	.w22       (w22),
	.out_pixel (out_pixel)
);

`default_nettype wire

// File: sim/tb_dpc_top.sv
`default_nettype none

module tb_dpc_top
	import dpc_pixel_pkg::*;
	import dpc_stream_pkg::*;
();

	localparam int clk_period   = 100;
	localparam int reset_cycles = 5;
	localparam int phase_cycles = 300;
	localparam int phase_count  = 5;
	localparam int total_cycles = reset_cycles + 1 + phase_count * phase_cycles;

	// ends of the basic directions h, v, d1, d2 as row and column
	localparam int dir_r0 [4] = '{1, 0, 0, 0};
	localparam int dir_c0 [4] = '{0, 1, 0, 2};
	localparam int dir_r1 [4] = '{1, 2, 2, 2};
	localparam int dir_c1 [4] = '{2, 1, 2, 0};

	typedef struct packed {
		logic   ok;
		diff_t  diff;
		pixel_t value;
	} cand_t;

	logic        aclk;
	logic        aresetn;
	logic        in_valid;
	logic        is_first_row;
	logic        is_last_row;
	logic        is_first_column;
	logic        is_last_column;
	coord_t      in_hcnt;
	coord_t      in_vcnt;
	pixel_word_u w11, w12, w13;
	pixel_word_u w21, w22, w23;
	pixel_word_u w31, w32, w33;
	pixel_word_u out_pixel;
	coord_t      out_hcnt;
	coord_t      out_vcnt;
	logic        out_valid;

	// stimulus of the current cycle
	pixel_word_u win [3][3];
	logic        first_row, last_row, first_col, last_col;
	logic        next_valid;
	coord_t      next_hcnt, next_vcnt;

	logic [31:0] rng_state;
	int          cycle;

	int          exp_tag   [$];
	string       exp_name  [$];
	pixel_word_u exp_pixel [$];
	coord_t      exp_hcnt  [$];
	coord_t      exp_vcnt  [$];
	logic        exp_valid [$];

	dpc_top dut_i (.*);

	initial begin
		aclk = 1'b0;
		forever #(clk_period / 2) aclk = ~aclk;
	end

	////////////////////////////////////////////////////////////////////////////
	// random numbers and reference model

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	function automatic diff_t distance(input pixel_t a, input pixel_t b);
		if (a >= b) begin
			return a - b;
		end else begin
			return b - a;
		end
	endfunction

	// later candidate takes ties
	function automatic cand_t choose(input cand_t a, input cand_t b);
		cand_t empty;
		empty.ok    = 1'b0;
		empty.diff  = '1;
		empty.value = '0;
		if (a.ok && b.ok) begin
			return (a.diff < b.diff) ? a : b;
		end
		if (a.ok) begin
			return a;
		end
		if (b.ok) begin
			return b;
		end
		return empty;
	endfunction

	function automatic cand_t basic_cand(input pixel_t a, input logic bad_a,
		input pixel_t b, input logic bad_b);
		cand_t      c;
		logic [8:0] sum;
		sum     = {1'b0, a} + {1'b0, b};
		c.ok    = !bad_a && !bad_b;
		c.diff  = distance(a, b);
		c.value = sum[8:1];
		return c;
	endfunction

	function automatic cand_t adj_cand(input pixel_t a, input logic bad_a,
		input pixel_t b, input logic bad_b, input pixel_t r, input logic bad_r);
		cand_t c;
		c.ok    = !bad_a && !bad_b && !bad_r;
		c.diff  = distance(a, b);
		c.value = r;
		return c;
	endfunction

	function automatic pixel_word_u model_pixel();
		pixel_t      p [3][3];
		logic        b [3][3];
		cand_t       dir [4];
		cand_t       basic, up, down, left, right, adj;
		logic [2:0]  count;
		pixel_t      repl;
		pixel_word_u result;
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				p[i][j] = win[i][j].fields.value;
				b[i][j] = win[i][j].fields.bad;
			end
		end
		// rows first, then columns, so corners take the center
		for (int c = 0; c < 3; c++) begin
			if (first_row) p[0][c] = p[1][c];
			if (last_row) p[2][c] = p[1][c];
		end
		for (int r = 0; r < 3; r++) begin
			if (first_col) p[r][0] = p[r][1];
			if (last_col) p[r][2] = p[r][1];
		end
		count = '0;
		for (int k = 0; k < 4; k++) begin
			dir[k] = basic_cand(p[dir_r0[k]][dir_c0[k]], b[dir_r0[k]][dir_c0[k]],
				p[dir_r1[k]][dir_c1[k]], b[dir_r1[k]][dir_c1[k]]);
			count = count + {2'b00, dir[k].ok};
		end
		basic = choose(choose(dir[0], dir[1]), choose(dir[2], dir[3]));
		up = choose(adj_cand(p[0][0], b[0][0], p[0][1], b[0][1], p[1][0], b[1][0]),
			adj_cand(p[0][2], b[0][2], p[0][1], b[0][1], p[1][2], b[1][2]));
		down = choose(adj_cand(p[2][0], b[2][0], p[2][1], b[2][1], p[1][0], b[1][0]),
			adj_cand(p[2][2], b[2][2], p[2][1], b[2][1], p[1][2], b[1][2]));
		left = choose(adj_cand(p[0][0], b[0][0], p[1][0], b[1][0], p[0][1], b[0][1]),
			adj_cand(p[2][0], b[2][0], p[1][0], b[1][0], p[2][1], b[2][1]));
		right = choose(adj_cand(p[0][2], b[0][2], p[1][2], b[1][2], p[0][1], b[0][1]),
			adj_cand(p[2][2], b[2][2], p[1][2], b[1][2], p[2][1], b[2][1]));
		adj = choose(choose(up, down), choose(left, right));
		repl = (count >= 3'd2 || basic.diff < adj.diff) ? basic.value : adj.value;
		result.fields.bad   = b[1][1];
		result.fields.value = b[1][1] ? repl : p[1][1];
		return result;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stimulus

	function automatic string phase_name(input int phase);
		case (phase)
			0: return "timing";
			1: return "pass_through";
			2: return "basic_mean";
			3: return "adjacent_fallback";
			default: return "border";
		endcase
	endfunction

	task automatic clear_stimulus();
		next_valid = 1'b0;
		next_hcnt  = '0;
		next_vcnt  = '0;
		first_row  = 1'b0;
		last_row   = 1'b0;
		first_col  = 1'b0;
		last_col   = 1'b0;
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				win[i][j] = '0;
			end
		end
	endtask

	task automatic make_stimulus(input int phase);
		logic [31:0] r;
		logic        found;
		r = next_random();
		next_valid = (r[1:0] != 2'b00);
		next_hcnt  = r[17:8];
		next_vcnt  = r[27:18];
		r = next_random();
		first_row = (phase == 0 || phase == 4) && r[0];
		last_row  = (phase == 0 || phase == 4) && r[1];
		first_col = (phase == 0 || phase == 4) && r[2];
		last_col  = (phase == 0 || phase == 4) && r[3];
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				r = next_random();
				win[i][j].fields.value = r[15:8];
				// narrow range so equal differences show up
				if (phase == 2 && r[16]) begin
					win[i][j].fields.value = {4'h8, r[11:8]};
				end
				case (phase)
					2: win[i][j].fields.bad = 1'b0;
					3: win[i][j].fields.bad = r[0];
					default: win[i][j].fields.bad = (r[1:0] == 2'b00);
				endcase
			end
		end
		if (phase == 1) begin
			win[1][1].fields.bad = 1'b0;
		end else if (phase >= 2) begin
			win[1][1].fields.bad = 1'b1;
		end
		// keep at most one basic direction usable
		if (phase == 3) begin
			found = 1'b0;
			for (int k = 0; k < 4; k++) begin
				if (!win[dir_r0[k]][dir_c0[k]].fields.bad &&
					!win[dir_r1[k]][dir_c1[k]].fields.bad) begin
					if (found) begin
						r = next_random();
						if (r[0]) begin
							win[dir_r0[k]][dir_c0[k]].fields.bad = 1'b1;
						end else begin
							win[dir_r1[k]][dir_c1[k]].fields.bad = 1'b1;
						end
					end
					found = 1'b1;
				end
			end
		end
	endtask

	task automatic drive_inputs();
		in_valid        <= next_valid;
		in_hcnt         <= next_hcnt;
		in_vcnt         <= next_vcnt;
		is_first_row    <= first_row;
		is_last_row     <= last_row;
		is_first_column <= first_col;
		is_last_column  <= last_col;
		w11 <= win[0][0];
		w12 <= win[0][1];
		w13 <= win[0][2];
		w21 <= win[1][0];
		w22 <= win[1][1];
		w23 <= win[1][2];
		w31 <= win[2][0];
		w32 <= win[2][1];
		w33 <= win[2][2];
	endtask

	task automatic push_expected(input string name);
		exp_tag.push_back(cycle + pipe_latency);
		exp_name.push_back(name);
		exp_pixel.push_back(model_pixel());
		exp_hcnt.push_back(next_hcnt);
		exp_vcnt.push_back(next_vcnt);
		exp_valid.push_back(next_valid);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// checks

	task automatic check_pixel(input string name, input pixel_word_u expected,
		input pixel_word_u actual);
		if (actual.raw !== expected.raw) begin
			$display("FAIL %s pixel: expected %h actual %h", name, expected.raw, actual.raw);
			$display("SIMULATION FAILED");
			$fatal(1, "pixel mismatch");
		end
	endtask

	task automatic check_coord(input string name, input coord_t expected, input coord_t actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected %0d actual %0d", name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "coordinate mismatch");
		end
	endtask

	task automatic check_valid(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAIL %s valid: expected %b actual %b", name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "valid mismatch");
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge aclk) begin
		if (exp_tag.size() != 0 && exp_tag[0] == cycle) begin
			check_pixel(exp_name[0], exp_pixel[0], out_pixel);
			check_coord({exp_name[0], " hcnt"}, exp_hcnt[0], out_hcnt);
			check_coord({exp_name[0], " vcnt"}, exp_vcnt[0], out_vcnt);
			check_valid(exp_name[0], exp_valid[0], out_valid);
			void'(exp_tag.pop_front());
			void'(exp_name.pop_front());
			void'(exp_pixel.pop_front());
			void'(exp_hcnt.pop_front());
			void'(exp_vcnt.pop_front());
			void'(exp_valid.pop_front());
		end else if (cycle > 0) begin
			check_valid("reset", 1'b0, out_valid);
		end
	end

	initial begin
		#((total_cycles + 20) * clk_period);
		$display("watchdog: run timed out after %0d cycles", total_cycles + 20);
		$display("SIMULATION FAILED");
		$fatal(1, "timeout");
	end

	////////////////////////////////////////////////////////////////////////////
	// main sequence

	initial begin
		rng_state       = 32'd63654;
		cycle           = 0;
		aresetn         = 1'b0;
		in_valid        = 1'b0;
		in_hcnt         = '0;
		in_vcnt         = '0;
		is_first_row    = 1'b0;
		is_last_row     = 1'b0;
		is_first_column = 1'b0;
		is_last_column  = 1'b0;
		w11 = '0;
		w12 = '0;
		w13 = '0;
		w21 = '0;
		w22 = '0;
		w23 = '0;
		w31 = '0;
		w32 = '0;
		w33 = '0;
		clear_stimulus();
		// an all zero window gives the same all zero output as a cleared pipe
		repeat (reset_cycles) begin
			@(posedge aclk);
			cycle = cycle + 1;
			push_expected("reset");
		end
		@(posedge aclk);
		cycle = cycle + 1;
		aresetn <= 1'b1;
		push_expected("reset");
		for (int ph = 0; ph < phase_count; ph++) begin
			repeat (phase_cycles) begin
				@(posedge aclk);
				cycle = cycle + 1;
				make_stimulus(ph);
				push_expected(phase_name(ph));
				drive_inputs();
			end
		end
		// drain the pipe while the cycle count keeps running
		while (exp_tag.size() != 0) begin
			@(posedge aclk);
			cycle = cycle + 1;
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: dpc_top.f
hw/dpc_pixel_pkg.sv
hw/dpc_stream_pkg.sv
hw/dpc_window_prep.sv
hw/dpc_basic_select.sv
hw/dpc_adjacent_select.sv
hw/dpc_replace.sv
hw/dpc_top.sv
sim/dpc_top_assert.sv
sim/tb_dpc_top.sv

// File: Makefile
TOP := tb_dpc_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f dpc_top.f --top-module dpc_top
	verilator --lint-only --timing --assert -f dpc_top.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f dpc_top.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; \
	status=$$?; \
	cat sim.log; \
	if grep -q "SIMULATION FAILED" sim.log || [ $$status -ne 0 ]; then \
		echo "sim: run failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
